//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tpu_tb
FILELIST := tpu_top.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) dv/tpu_testdata.hex
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial clk = 1'b0;
    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- dv/tpu_tb.sv
`default_nettype none

module tpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import tpu_cfg_pkg::*;

    localparam int DIM_W       = DIM_W_DEFAULT;
    localparam int INDEX_W     = INDEX_W_DEFAULT;
    localparam int BUF_WORDS   = 2**INDEX_W;
    localparam int DATA_WORDS  = 1024;
    localparam int JOB_TIMEOUT = 5000;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic [DIM_W-1:0]   k_dim;
    logic [DIM_W-1:0]   m_dim;
    logic [DIM_W-1:0]   n_dim;
    acc_t               input_offset;
    ab_word_t           a_data_out = '0;
    ab_word_t           b_data_out = '0;
    c_word_t            c_data_out;
    logic               busy;
    logic [INDEX_W-1:0] a_index;
    logic [INDEX_W-1:0] b_index;
    logic               c_wr_en;
    logic [INDEX_W-1:0] c_index;
    c_word_t            c_data_in;
    logic [INDEX_W-1:0] a_rd_index = '0;
    logic [INDEX_W-1:0] b_rd_index = '0;

    logic [31:0] testdata [DATA_WORDS];
    ab_word_t    a_mem [BUF_WORDS];
    ab_word_t    b_mem [BUF_WORDS];
    c_word_t     exp_c [BUF_WORDS];
    c_word_t     got_c [BUF_WORDS];
    int          write_cnt [BUF_WORDS];
    int          total_writes = 0;

    tb_clock_gen i_clock_gen (.clk(clk));

    tpu_top #(
        .DIM_W   (DIM_W),
        .INDEX_W (INDEX_W)
    ) i_tpu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .k_dim        (k_dim),
        .m_dim        (m_dim),
        .n_dim        (n_dim),
        .input_offset (input_offset),
        .a_data_out   (a_data_out),
        .b_data_out   (b_data_out),
        .c_data_out   (c_data_out),
        .busy         (busy),
        .a_index      (a_index),
        .b_index      (b_index),
        .c_wr_en      (c_wr_en),
        .c_index      (c_index),
        .c_data_in    (c_data_in)
    );

    task automatic check_c_word(input c_word_t got, input c_word_t exp, input int idx);
        if (got !== exp) begin
            $display("FAILED at %0t: C word %0d is %h, expected %h", $time, idx, got, exp);
            $display("TEST FAILED");
            $fatal(1, "C word mismatch");
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, busy is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "busy mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // buffers answer one cycle after the index
    always @(negedge clk) begin
        a_rd_index <= a_index;
        b_rd_index <= b_index;
        a_data_out <= a_mem[a_rd_index];
        b_data_out <= b_mem[b_rd_index];
    end

    // C buffer write port into the scoreboard
    always @(negedge clk) begin
        if (c_wr_en === 1'b1) begin
            check_busy(busy, 1'b1, "C write seen with busy low");
            got_c[c_index] = c_data_in;
            write_cnt[c_index] = write_cnt[c_index] + 1;
            total_writes = total_writes + 1;
        end
    end

    task automatic run_job(inout int pos);
        int   k;
        int   m;
        int   n;
        int   nc;
        int   cycles;
        int   writes_at_end;
        acc_t off;
        k   = testdata[pos];
        m   = testdata[pos+1];
        n   = testdata[pos+2];
        off = testdata[pos+3];
        pos = pos + 4;
        nc  = (n / 4) * m;
        for (int i = 0; i < (m / 4) * k; i++) begin
            a_mem[i] = testdata[pos];
            pos = pos + 1;
        end
        for (int i = 0; i < (n / 4) * k; i++) begin
            b_mem[i] = testdata[pos];
            pos = pos + 1;
        end
        // four lanes per C word with lane 0 first
        for (int i = 0; i < nc; i++) begin
            exp_c[i] = {testdata[pos], testdata[pos+1], testdata[pos+2], testdata[pos+3]};
            pos = pos + 4;
        end
        foreach (write_cnt[i]) write_cnt[i] = 0;
        total_writes = 0;

        @(negedge clk);
        k_dim        <= DIM_W'(k);
        m_dim        <= DIM_W'(m);
        n_dim        <= DIM_W'(n);
        input_offset <= off;
        in_valid     <= 1'b1;
        @(negedge clk);
        in_valid <= 1'b0;
        check_busy(busy, 1'b1, "busy one cycle after in_valid");

        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > JOB_TIMEOUT) begin
                $display("busy never fell within %0d cycles (K=%0d M=%0d N=%0d)",
                         JOB_TIMEOUT, k, m, n);
                $display("TEST FAILED");
                $fatal(1, "job timeout");
            end
        end
        writes_at_end = total_writes;
        check_count(writes_at_end, nc, "C writes while busy");

        repeat (10) @(negedge clk);
        @(posedge clk);
        check_count(total_writes, writes_at_end, "C writes after busy fell");
        for (int i = 0; i < nc; i++) begin
            check_count(write_cnt[i], 1, $sformatf("writes to C index %0d", i));
            check_c_word(got_c[i], exp_c[i], i);
        end
    endtask

    initial begin
        int pos;
        int jobs;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        k_dim        = '0;
        m_dim        = '0;
        n_dim        = '0;
        input_offset = '0;
        c_data_out   = '0;
        pos          = 0;
        jobs         = 0;
        $readmemh("dv/tpu_testdata.hex", testdata);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;

        // idle after reset
        repeat (5) @(negedge clk);
        check_busy(busy, 1'b0, "busy after reset");
        check_busy(c_wr_en, 1'b0, "c_wr_en after reset");
        check_count(total_writes, 0, "C writes before in_valid");

        while (pos < DATA_WORDS - 4 && testdata[pos] != 0) begin
            run_job(pos);
            jobs = jobs + 1;
        end

        if (jobs == 0) begin
            $display("no job found in the data file");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/tpu_testdata.hex
// job: header K M N offset, then A words, B words, C words (4 lanes, lane 0 first)
// a zero K ends the list
00000001 00000004 00000004 00000000
03FE05F9
02FF0406
00000006 FFFFFFFD 0000000C 00000012
FFFFFFFC 00000002 FFFFFFF8 FFFFFFF4
0000000A FFFFFFFB 00000014 0000001E
FFFFFFF2 00000007 FFFFFFE4 FFFFFFD6
// K=5 M=8 N=8 offset -1
00000005 00000008 00000008 FFFFFFFF
01020304 00010203 FF000102 FEFF0001 FDFEFF00
05060708 04050607 03040506 02030405 01020304
00010203 FF000102 FEFF0001 FDFEFF00 FCFDFEFF
04050607 03040506 02030405 01020304 00010203
0000001E 00000014 0000000A 00000000
00000014 0000000F 0000000A 00000005
0000000A 0000000A 0000000A 0000000A
00000000 00000005 0000000A 0000000F
FFFFFFF6 00000000 0000000A 00000014
FFFFFFEC FFFFFFFB 0000000A 00000019
FFFFFFE2 FFFFFFF6 0000000A 0000001E
FFFFFFD8 FFFFFFF1 0000000A 00000023
FFFFFFF6 FFFFFFEC FFFFFFE2 FFFFFFD8
00000000 FFFFFFFB FFFFFFF6 FFFFFFF1
0000000A 0000000A 0000000A 0000000A
00000014 00000019 0000001E 00000023
0000001E 00000028 00000032 0000003C
00000028 00000037 00000046 00000055
00000032 00000046 0000005A 0000006E
0000003C 00000055 0000006E 00000087
// K=2 M=4 N=4 offset 3
00000002 00000004 00000004 00000003
FDFEFF00 FBFCFDFE
01020304 02020202
FFFFFFFC FFFFFFFC FFFFFFFC FFFFFFFC
FFFFFFFF 00000000 00000001 00000002
00000002 00000004 00000006 00000008
00000005 00000008 0000000B 0000000E
00000000

//--- hdl/mac_pe.sv
`default_nettype none

module mac_pe (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire tpu_cfg_pkg::operand_t a_in,
    input  wire tpu_cfg_pkg::operand_t b_in,
    input  wire                        valid_in,
    input  wire                        first_in,
    input  wire tpu_cfg_pkg::acc_t     offset,
    output tpu_cfg_pkg::operand_t      a_out,
    output tpu_cfg_pkg::operand_t      b_out,
    output logic                       valid_out,
    output logic                       first_out,
    output tpu_cfg_pkg::acc_t          acc
);
    import tpu_cfg_pkg::*;

    acc_t product;

    // offset goes on the A side only
    assign product = (acc_t'(a_in) + offset) * acc_t'(b_in);

    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
        // first product of a tile replaces the old sum
        if (valid_in) begin
            acc <= first_in ? product : acc + product;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            first_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
            first_out <= first_in;
        end
    end

endmodule

`default_nettype wire

//--- hdl/operand_skew.sv
`default_nettype none

module operand_skew (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        rd_strobe,
    input  wire                        first_rd,
    input  wire tpu_cfg_pkg::ab_word_t a_data,
    input  wire tpu_cfg_pkg::ab_word_t b_data,
    output tpu_cfg_pkg::operand_t [tpu_cfg_pkg::ARRAY_DIM-1:0] a_lane,
    output tpu_cfg_pkg::operand_t [tpu_cfg_pkg::ARRAY_DIM-1:0] b_lane,
    output logic [tpu_cfg_pkg::ARRAY_DIM-1:0] lane_valid,
    output logic [tpu_cfg_pkg::ARRAY_DIM-1:0] lane_first
);
    import tpu_cfg_pkg::*;

    logic strobe_d;
    logic first_d;

    // lines up with the buffer read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_d <= 1'b0;
            first_d  <= 1'b0;
        end else begin
            strobe_d <= rd_strobe;
            first_d  <= first_rd;
        end
    end

    // lane n gets n+1 stages
    for (genvar n = 0; n < ARRAY_DIM; n++) begin : g_lane
        operand_t   a_pipe [n+1];
        operand_t   b_pipe [n+1];
        logic [0:n] v_pipe;
        logic [0:n] f_pipe;

        always_ff @(posedge clk) begin
            a_pipe[0] <= a_data[(ARRAY_DIM-1-n)*$bits(operand_t) +: $bits(operand_t)];
            b_pipe[0] <= b_data[(ARRAY_DIM-1-n)*$bits(operand_t) +: $bits(operand_t)];
            for (int s = 1; s <= n; s++) begin
                a_pipe[s] <= a_pipe[s-1];
                b_pipe[s] <= b_pipe[s-1];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                v_pipe <= '0;
                f_pipe <= '0;
            end else begin
                v_pipe[0] <= strobe_d;
                f_pipe[0] <= first_d;
                for (int s = 1; s <= n; s++) begin
                    v_pipe[s] <= v_pipe[s-1];
                    f_pipe[s] <= f_pipe[s-1];
                end
            end
        end

        assign a_lane[n]     = a_pipe[n];
        assign b_lane[n]     = b_pipe[n];
        assign lane_valid[n] = v_pipe[n];
        assign lane_first[n] = f_pipe[n];
    end

endmodule

`default_nettype wire

//--- hdl/result_writer.sv
`default_nettype none

module result_writer #(
    parameter int INDEX_W = tpu_cfg_pkg::INDEX_W_DEFAULT
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                tile_done,
    input  wire  [INDEX_W-1:0] tile_c_base,
    input  wire tpu_cfg_pkg::acc_t [tpu_cfg_pkg::ARRAY_DIM-1:0][tpu_cfg_pkg::ARRAY_DIM-1:0] acc_grid,
    output logic               c_wr_en,
    output logic [INDEX_W-1:0] c_index,
    output tpu_cfg_pkg::c_word_t c_data_in,
    output logic               wb_active
);
    import tpu_cfg_pkg::*;

    acc_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] bank;
    logic [INDEX_W-1:0]                  base;
    logic [1:0]                          row;
    logic                                active;
    logic                                last_row;

    // snapshot frees the grid for the next tile
    always_ff @(posedge clk) begin
        if (tile_done) begin
            bank <= acc_grid;
            base <= tile_c_base;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            row    <= '0;
        end else if (tile_done) begin
            active <= 1'b1;
            row    <= '0;
        end else if (active) begin
            row <= row + 1'b1;
            if (last_row) begin
                active <= 1'b0;
            end
        end
    end

    assign last_row = (row == 2'(ARRAY_DIM - 1));

    // row j of the tile is cells (0..3, j), column 0 on top
    always_comb begin
        for (int i = 0; i < ARRAY_DIM; i++) begin
            c_data_in[(ARRAY_DIM-1-i)*$bits(acc_t) +: $bits(acc_t)] = bank[i][row];
        end
    end

    assign c_wr_en = active;
    assign c_index = base + INDEX_W'(row);

    // drops with the last row so busy can fall right after it
    assign wb_active = active && !last_row;

endmodule

`default_nettype wire

//--- hdl/systolic_array.sv
`default_nettype none

module systolic_array (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire tpu_cfg_pkg::operand_t [tpu_cfg_pkg::ARRAY_DIM-1:0] a_lane,
    input  wire tpu_cfg_pkg::operand_t [tpu_cfg_pkg::ARRAY_DIM-1:0] b_lane,
    input  wire [tpu_cfg_pkg::ARRAY_DIM-1:0] lane_valid,
    input  wire [tpu_cfg_pkg::ARRAY_DIM-1:0] lane_first,
    input  wire tpu_cfg_pkg::acc_t     offset,
    output tpu_cfg_pkg::acc_t [tpu_cfg_pkg::ARRAY_DIM-1:0][tpu_cfg_pkg::ARRAY_DIM-1:0] acc_grid
);
    import tpu_cfg_pkg::*;

    // A and flags move down through rows i, B moves across columns j
    operand_t a_v [ARRAY_DIM+1][ARRAY_DIM];
    logic     v_v [ARRAY_DIM+1][ARRAY_DIM];
    logic     f_v [ARRAY_DIM+1][ARRAY_DIM];
    operand_t b_h [ARRAY_DIM][ARRAY_DIM+1];

    for (genvar n = 0; n < ARRAY_DIM; n++) begin : g_edge
        assign a_v[0][n] = a_lane[n];
        assign v_v[0][n] = lane_valid[n];
        assign f_v[0][n] = lane_first[n];
        assign b_h[n][0] = b_lane[n];
    end

    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
            mac_pe i_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .a_in      (a_v[i][j]),
                .b_in      (b_h[i][j]),
                .valid_in  (v_v[i][j]),
                .first_in  (f_v[i][j]),
                .offset    (offset),
                .a_out     (a_v[i+1][j]),
                .b_out     (b_h[i][j+1]),
                .valid_out (v_v[i+1][j]),
                .first_out (f_v[i+1][j]),
                .acc       (acc_grid[i][j])
            );
        end
    end

endmodule

`default_nettype wire

//--- hdl/tile_sequencer.sv
`default_nettype none

module tile_sequencer #(
    parameter int DIM_W   = tpu_cfg_pkg::DIM_W_DEFAULT,
    parameter int INDEX_W = tpu_cfg_pkg::INDEX_W_DEFAULT
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                in_valid,
    input  wire  [DIM_W-1:0]   k_dim,
    input  wire  [DIM_W-1:0]   m_dim,
    input  wire  [DIM_W-1:0]   n_dim,
    input  wire                wb_active,
    output logic [INDEX_W-1:0] a_index,
    output logic [INDEX_W-1:0] b_index,
    output logic               rd_strobe,
    output logic               first_rd,
    output logic               tile_done,
    output logic [INDEX_W-1:0] tile_c_base,
    output logic               busy
);
    import tpu_ctrl_pkg::*;

    seq_state_t         state;
    logic [DIM_W-1:0]   k_reg;
    logic [DIM_W-3:0]   t_last;
    logic [DIM_W-3:0]   u_last;
    logic [DIM_W-1:0]   k_cnt;
    logic [DIM_W-3:0]   t_cnt;
    logic [DIM_W-3:0]   u_cnt;
    logic [INDEX_W-1:0] b_base;
    logic [3:0]         drain_cnt;
    logic               last_tile;
    logic               job_start;
    logic               last_rd;
    logic               t_wrap;

    assign job_start = (state == IDLE) && in_valid;
    assign rd_strobe = (state == STREAM);
    assign first_rd  = rd_strobe && (k_cnt == '0);
    assign last_rd   = rd_strobe && (k_cnt == k_reg - 1'b1);
    assign t_wrap    = (t_cnt == t_last);

    // tile counts kept as count-1, M and N are multiples of 4
    always_ff @(posedge clk) begin
        if (job_start) begin
            k_reg  <= k_dim;
            t_last <= m_dim[DIM_W-1:2] - 1'b1;
            u_last <= n_dim[DIM_W-1:2] - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            busy      <= 1'b0;
            tile_done <= 1'b0;
            k_cnt     <= '0;
            t_cnt     <= '0;
            u_cnt     <= '0;
            drain_cnt <= '0;
            last_tile <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        state <= STREAM;
                        busy  <= 1'b1;
                        k_cnt <= '0;
                        t_cnt <= '0;
                        u_cnt <= '0;
                    end
                end
                STREAM: begin
                    if (last_rd) begin
                        state     <= DRAIN;
                        k_cnt     <= '0;
                        drain_cnt <= 4'd1;
                        last_tile <= t_wrap && (u_cnt == u_last);
                        if (t_wrap) begin
                            t_cnt <= '0;
                            u_cnt <= u_cnt + 1'b1;
                        end else begin
                            t_cnt <= t_cnt + 1'b1;
                        end
                    end else begin
                        k_cnt <= k_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    // next tile reads start alongside tile_done
                    if (drain_cnt == 4'(ARRAY_DRAIN - 1)) begin
                        tile_done <= 1'b1;
                        state     <= last_tile ? WAIT_WB : STREAM;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                WAIT_WB: begin
                    if (!tile_done && !wb_active) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // running buffer indices, no multipliers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_index     <= '0;
            b_index     <= '0;
            b_base      <= '0;
            tile_c_base <= '0;
        end else begin
            if (job_start) begin
                a_index     <= '0;
                b_index     <= '0;
                b_base      <= '0;
                tile_c_base <= '0;
            end else if (last_rd && t_wrap) begin
                // next B column block, A back to the top
                a_index <= '0;
                b_index <= b_index + 1'b1;
                b_base  <= b_index + 1'b1;
            end else if (last_rd) begin
                a_index <= a_index + 1'b1;
                b_index <= b_base;
            end else if (rd_strobe) begin
                a_index <= a_index + 1'b1;
                b_index <= b_index + 1'b1;
            end
            // u*M + 4t steps by 4 per tile, t runs inner
            if (tile_done) begin
                tile_c_base <= tile_c_base + INDEX_W'(4);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tpu_cfg_pkg.sv
`default_nettype none

package tpu_cfg_pkg;

    // grid edge, also the tile height and width
    parameter int ARRAY_DIM = 4;

    // one matrix element of A or B
    typedef logic signed [7:0] operand_t;

    // accumulator, also the A offset
    typedef logic signed [31:0] acc_t;

    // A or B buffer word, lane 0 in the top byte
    typedef logic [ARRAY_DIM*$bits(operand_t)-1:0] ab_word_t;

    // C buffer word, one row of a tile, lane 0 in the top 32 bits
    typedef logic [ARRAY_DIM*$bits(acc_t)-1:0] c_word_t;

    // dimension width and buffer index width
    parameter int DIM_W_DEFAULT   = 11;
    parameter int INDEX_W_DEFAULT = 15;

endpackage

`default_nettype wire

//--- hdl/tpu_ctrl_pkg.sv
`default_nettype none

package tpu_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DRAIN,
        WAIT_WB
    } seq_state_t;

    // last read to last accumulate in cell (3,3)
    // buffer latency + input register + 6 hops + accumulator register
    parameter int ARRAY_DRAIN = 9;

endpackage

`default_nettype wire

//--- hdl/tpu_top.sv
`default_nettype none

module tpu_top #(
    parameter int DIM_W   = tpu_cfg_pkg::DIM_W_DEFAULT,
    parameter int INDEX_W = tpu_cfg_pkg::INDEX_W_DEFAULT
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        in_valid,
    input  wire  [DIM_W-1:0]           k_dim,
    input  wire  [DIM_W-1:0]           m_dim,
    input  wire  [DIM_W-1:0]           n_dim,
    input  wire tpu_cfg_pkg::acc_t     input_offset,
    input  wire tpu_cfg_pkg::ab_word_t a_data_out,
    input  wire tpu_cfg_pkg::ab_word_t b_data_out,
    input  wire tpu_cfg_pkg::c_word_t  c_data_out,
    output logic                       busy,
    output logic [INDEX_W-1:0]         a_index,
    output logic [INDEX_W-1:0]         b_index,
    output logic                       c_wr_en,
    output logic [INDEX_W-1:0]         c_index,
    output tpu_cfg_pkg::c_word_t       c_data_in
);
    import tpu_cfg_pkg::*;

    logic                                rd_strobe;
    logic                                first_rd;
    logic                                tile_done;
    logic [INDEX_W-1:0]                  tile_c_base;
    logic                                wb_active;
    operand_t [ARRAY_DIM-1:0]            a_lane;
    operand_t [ARRAY_DIM-1:0]            b_lane;
    logic [ARRAY_DIM-1:0]                lane_valid;
    logic [ARRAY_DIM-1:0]                lane_first;
    acc_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] acc_grid;

    tile_sequencer #(
        .DIM_W   (DIM_W),
        .INDEX_W (INDEX_W)
    ) i_tile_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .k_dim       (k_dim),
        .m_dim       (m_dim),
        .n_dim       (n_dim),
        .wb_active   (wb_active),
        .a_index     (a_index),
        .b_index     (b_index),
        .rd_strobe   (rd_strobe),
        .first_rd    (first_rd),
        .tile_done   (tile_done),
        .tile_c_base (tile_c_base),
        .busy        (busy)
    );

    operand_skew i_operand_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_strobe  (rd_strobe),
        .first_rd   (first_rd),
        .a_data     (a_data_out),
        .b_data     (b_data_out),
        .a_lane     (a_lane),
        .b_lane     (b_lane),
        .lane_valid (lane_valid),
        .lane_first (lane_first)
    );

    systolic_array i_systolic_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_lane     (a_lane),
        .b_lane     (b_lane),
        .lane_valid (lane_valid),
        .lane_first (lane_first),
        .offset     (input_offset),
        .acc_grid   (acc_grid)
    );

    result_writer #(
        .INDEX_W (INDEX_W)
    ) i_result_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .tile_done   (tile_done),
        .tile_c_base (tile_c_base),
        .acc_grid    (acc_grid),
        .c_wr_en     (c_wr_en),
        .c_index     (c_index),
        .c_data_in   (c_data_in),
        .wb_active   (wb_active)
    );

endmodule

`default_nettype wire

//--- tpu_top.f
hdl/tpu_cfg_pkg.sv
hdl/tpu_ctrl_pkg.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/operand_skew.sv
hdl/tile_sequencer.sv
hdl/result_writer.sv
hdl/tpu_top.sv
dv/tb_clock_gen.sv
dv/tpu_tb.sv
